// ==== verilog/tetris_macros.svh ====
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// Playfield size in cells
`define BOARD_COLS 10
`define BOARD_ROWS 20

// Cell size in pixels and top-left corner of the playfield
`define CELL_PX  16
`define BOARD_X0 240
`define BOARD_Y0 80

// 640x480 horizontal timing in pixel clocks
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_BACK    48
`define H_TOTAL   (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_BACK    33
`define V_TOTAL   (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

// Gravity intervals in clock cycles
`define DROP_BASE 100
`define DROP_STEP 8
`define DROP_MIN  20
`define DROP_FAST 10

`endif

// ==== verilog/tetris_pkg.sv ====
`include "tetris_macros.svh"

package tetris_pkg;

  // One bit per gun, red in the top bit
  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } color_t;

  localparam color_t color_black   = color_t'(3'b000);
  localparam color_t color_red     = color_t'(3'b100);
  localparam color_t color_green   = color_t'(3'b010);
  localparam color_t color_blue    = color_t'(3'b001);
  localparam color_t color_yellow  = color_t'(3'b110);
  localparam color_t color_magenta = color_t'(3'b101);
  localparam color_t color_cyan    = color_t'(3'b011);
  localparam color_t color_white   = color_t'(3'b111);

  typedef enum logic {square, bar} piece_kind_t;

  typedef enum logic [2:0] {idle, fall, lock, clear, spawn, over} game_state_t;

  // Row 0 is the top of the playfield
  typedef logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] board_t;

  // Position is the top-left cell of the shape
  typedef struct packed {
    piece_kind_t kind;
    logic        vert;
    logic [3:0]  col;
    logic [4:0]  row;
  } piece_t;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic       active;
    logic       hsync;
    logic       vsync;
  } vga_pos_t;

  // Move fields are one-cycle pulses, speed is a level
  typedef struct packed {
    logic left;
    logic right;
    logic rotate;
    logic new_game;
    logic speed;
  } buttons_t;

  // Cells covered by a piece, cells past the edge are dropped
  function automatic board_t piece_cells(piece_t p);
    board_t cells;
    int r;
    int c;
    cells = '0;
    for (int i = 0; i < 4; i++) begin
      if (p.kind == square) begin
        r = int'(p.row) + i / 2;
        c = int'(p.col) + i % 2;
      end else if (p.vert) begin
        r = int'(p.row) + i;
        c = int'(p.col);
      end else begin
        r = int'(p.row);
        c = int'(p.col) + i;
      end
      if (r < `BOARD_ROWS && c < `BOARD_COLS) begin
        cells[r][c] = 1'b1;
      end
    end
    return cells;
  endfunction

endpackage

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module vga_timing
  import tetris_pkg::*;
(
  input  logic     hz100,
  input  logic     arst_n,
  output vga_pos_t pos
);

  // Sync pulse windows, start inclusive and end exclusive
  localparam logic [9:0] hs_start = 10'(`H_VISIBLE + `H_FRONT);
  localparam logic [9:0] hs_end   = 10'(`H_VISIBLE + `H_FRONT + `H_SYNC);
  localparam logic [9:0] vs_start = 10'(`V_VISIBLE + `V_FRONT);
  localparam logic [9:0] vs_end   = 10'(`V_VISIBLE + `V_FRONT + `V_SYNC);

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       line_end;
  logic       frame_end;

  assign line_end  = (h_cnt == 10'(`H_TOTAL - 1));
  assign frame_end = (v_cnt == 10'(`V_TOTAL - 1));

  // One pixel per clock, 800 pixels by 525 lines
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      if (frame_end) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 10'd1;
      end
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  // Position and syncs straight from the counters
  always_comb begin
    pos.x      = h_cnt;
    pos.y      = v_cnt;
    pos.active = (h_cnt < 10'(`H_VISIBLE)) && (v_cnt < 10'(`V_VISIBLE));
    // Both syncs active low
    pos.hsync  = !((h_cnt >= hs_start) && (h_cnt < hs_end));
    pos.vsync  = !((v_cnt >= vs_start) && (v_cnt < vs_end));
  end

endmodule

// ==== verilog/input_sync.sv ====
`timescale 1ns/1ps

module input_sync
  import tetris_pkg::*;
(
  input  logic        hz100,
  input  logic        arst_n,
  input  logic [20:0] pb,
  output buttons_t    buttons
);

  // Bit order: new game, rotate, left, right, speed
  logic [4:0] raw;
  logic [4:0] meta;
  logic [4:0] sync;
  logic [3:0] prev;
  logic [3:0] pulse;

  // Paired buttons merged before the synchronizer
  assign raw = {pb[19], pb[8] | pb[11], pb[3], pb[0], pb[12] | pb[15]};

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      meta  <= '0;
      sync  <= '0;
      prev  <= '0;
      pulse <= '0;
    end else begin
      meta  <= raw;
      sync  <= meta;
      prev  <= sync[4:1];
      // Rising edge, registered so the pulse lands 3 cycles after the press
      pulse <= sync[4:1] & ~prev;
    end
  end

  assign buttons.new_game = pulse[3];
  assign buttons.rotate   = pulse[2];
  assign buttons.left     = pulse[1];
  assign buttons.right    = pulse[0];
  // Speed is a level, 2 cycles behind the pin
  assign buttons.speed    = sync[0];

endmodule

// ==== verilog/drop_timer.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module drop_timer (
  input  logic       hz100,
  input  logic       arst_n,
  input  logic [6:0] score,
  input  logic       speed,
  output logic       tick
);

  logic [10:0] decay;
  logic [7:0]  interval;
  logic [7:0]  cnt;
  logic        speed_q;

  // Each point shortens the interval by DROP_STEP
  assign decay = 11'(score) * 11'(`DROP_STEP);

  always_comb begin
    if (speed) begin
      interval = 8'(`DROP_FAST);
    end else if (decay >= 11'(`DROP_BASE - `DROP_MIN)) begin
      // Floor reached
      interval = 8'(`DROP_MIN);
    end else begin
      interval = 8'(11'(`DROP_BASE) - decay);
    end
  end

  // Counts interval-1 down to 0, so the period is the interval
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= 8'(`DROP_BASE - 1);
      speed_q <= 1'b0;
    end else begin
      speed_q <= speed;
      // Speed toggle restarts the count at once
      if ((speed != speed_q) || (cnt == 8'd0)) begin
        cnt <= interval - 8'd1;
      end else begin
        cnt <= cnt - 8'd1;
      end
    end
  end

  assign tick = (cnt == 8'd0);

endmodule

// ==== verilog/tetris_fsm.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module tetris_fsm
  import tetris_pkg::*;
(
  input  logic       hz100,
  input  logic       arst_n,
  input  buttons_t   buttons,
  input  logic       tick,
  output board_t     board,
  output piece_t     piece,
  output logic       gameover,
  output logic [6:0] score
);

  localparam logic [3:0] spawn_col = 4'd3;
  localparam logic [4:0] last_row  = 5'(`BOARD_ROWS - 1);

  game_state_t state;
  piece_kind_t next_kind;
  logic [4:0]  clear_row;
  piece_t      move_piece;
  piece_t      down_piece;
  piece_t      spawn_piece;
  logic        move_req;
  logic        move_ok;
  logic        down_ok;
  logic        spawn_ok;
  logic        row_full;
  logic        tick_hold;
  board_t      shifted;

  // Shape extent must stay on the board
  function automatic logic in_bounds(piece_t p);
    int w;
    int h;
    if (p.kind == square) begin
      w = 2;
      h = 2;
    end else if (p.vert) begin
      w = 1;
      h = 4;
    end else begin
      w = 4;
      h = 1;
    end
    return (int'(p.col) + w <= `BOARD_COLS) && (int'(p.row) + h <= `BOARD_ROWS);
  endfunction

  function automatic logic fits(board_t b, piece_t p);
    return in_bounds(p) && ((piece_cells(p) & b) == '0);
  endfunction

  // Candidate after a move button
  always_comb begin
    move_piece = piece;
    move_req   = 1'b0;
    if (buttons.left) begin
      move_piece.col = piece.col - 4'd1;
      move_req       = 1'b1;
    end else if (buttons.right) begin
      move_piece.col = piece.col + 4'd1;
      move_req       = 1'b1;
    end else if (buttons.rotate && piece.kind == bar) begin
      // Bar turns about its second cell
      move_req = 1'b1;
      move_piece.vert = !piece.vert;
      if (piece.vert) begin
        move_piece.col = piece.col - 4'd1;
        move_piece.row = piece.row + 5'd1;
      end else begin
        // Wraps past the top edge on row 0 so in_bounds rejects it
        move_piece.col = piece.col + 4'd1;
        move_piece.row = piece.row - 5'd1;
      end
    end
  end

  always_comb begin
    down_piece     = piece;
    down_piece.row = piece.row + 5'd1;
    spawn_piece    = '{kind: next_kind, vert: 1'b0, col: spawn_col, row: 5'd0};
  end

  assign move_ok  = fits(board, move_piece);
  assign down_ok  = fits(board, down_piece);
  assign spawn_ok = fits(board, spawn_piece);
  assign row_full = &board[clear_row];

  // Rows above the checked row drop by one
  always_comb begin
    shifted    = board;
    shifted[0] = '0;
    for (int r = 1; r < `BOARD_ROWS; r++) begin
      if (5'(r) <= clear_row) begin
        shifted[r] = board[r-1];
      end
    end
  end

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= idle;
      board     <= '0;
      piece     <= '{kind: square, vert: 1'b0, col: spawn_col, row: 5'd0};
      next_kind <= square;
      clear_row <= last_row;
      score     <= '0;
      tick_hold <= 1'b0;
    end else if (buttons.new_game) begin
      // New game wins over every state
      state     <= spawn;
      board     <= '0;
      next_kind <= square;
      score     <= '0;
      tick_hold <= 1'b0;
    end else begin
      case (state)
        fall: begin
          if (move_req && move_ok) begin
            piece <= move_piece;
            // Tick in the same cycle is served one cycle later
            tick_hold <= tick_hold || tick;
          end else if (tick || tick_hold) begin
            tick_hold <= 1'b0;
            if (down_ok) begin
              piece <= down_piece;
            end else begin
              state <= lock;
            end
          end
        end
        lock: begin
          board     <= board | piece_cells(piece);
          clear_row <= last_row;
          state     <= clear;
        end
        clear: begin
          // Full row shifts down and the same row is checked again
          if (row_full) begin
            board <= shifted;
            if (score != 7'd99) begin
              score <= score + 7'd1;
            end
          end else if (clear_row == 5'd0) begin
            state <= spawn;
          end else begin
            clear_row <= clear_row - 5'd1;
          end
        end
        spawn: begin
          next_kind <= (next_kind == square) ? bar : square;
          if (spawn_ok) begin
            piece <= spawn_piece;
            state <= fall;
          end else begin
            state <= over;
          end
        end
        // Idle and over wait for new game
        default: begin
        end
      endcase
    end
  end

  assign gameover = (state == over);

endmodule

// ==== verilog/board_render.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module board_render
  import tetris_pkg::*;
(
  input  logic     hz100,
  input  logic     arst_n,
  input  vga_pos_t pos,
  input  board_t   board,
  input  piece_t   piece,
  input  logic     gameover,
  output color_t   vga_rgb,
  output logic     hsync,
  output logic     vsync
);

  // Frame box is the board plus one cell on every side
  localparam logic [9:0] frame_x0   = 10'(`BOARD_X0 - `CELL_PX);
  localparam logic [9:0] frame_y0   = 10'(`BOARD_Y0 - `CELL_PX);
  localparam logic [5:0] frame_cols = 6'(`BOARD_COLS + 2);
  localparam logic [5:0] frame_rows = 6'(`BOARD_ROWS + 2);

  logic [9:0] fx;
  logic [9:0] fy;
  logic [5:0] gc;
  logic [5:0] gr;
  logic       in_box;
  logic       on_frame;
  logic [3:0] cell_col;
  logic [4:0] cell_row;
  board_t     piece_mask;
  color_t     pix;

  // Left of or above the box wraps to a large value and falls outside
  assign fx       = pos.x - frame_x0;
  assign fy       = pos.y - frame_y0;
  assign gc       = 6'(fx / 10'(`CELL_PX));
  assign gr       = 6'(fy / 10'(`CELL_PX));
  assign in_box   = (gc < frame_cols) && (gr < frame_rows);
  assign on_frame = in_box && ((gc == 6'd0) || (gc == frame_cols - 6'd1) ||
                               (gr == 6'd0) || (gr == frame_rows - 6'd1));
  assign cell_col = 4'(gc - 6'd1);
  assign cell_row = 5'(gr - 6'd1);

  assign piece_mask = piece_cells(piece);

  // Piece, then locked cells, then frame, then background
  always_comb begin
    pix = color_black;
    if (pos.active && on_frame) begin
      pix = color_blue;
    end else if (pos.active && in_box) begin
      // Active piece hidden once the game is over
      if (!gameover && piece_mask[cell_row][cell_col]) begin
        pix = (piece.kind == square) ? color_yellow : color_cyan;
      end else if (board[cell_row][cell_col]) begin
        pix = gameover ? color_red : color_white;
      end
    end
  end

  // One cycle behind pos for color and syncs alike
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      vga_rgb <= color_black;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else begin
      vga_rgb <= pix;
      hsync   <= pos.hsync;
      vsync   <= pos.vsync;
    end
  end

endmodule

// ==== verilog/score_display.sv ====
`timescale 1ns/1ps

module score_display (
  input  logic [6:0] score,
  output logic [7:0] tens,
  output logic [7:0] units
);

  logic [3:0] tens_digit;
  logic [3:0] units_digit;

  // Segments a..g on bits 6..0, dot on bit 7 stays off
  function automatic logic [7:0] seg7(logic [3:0] d);
    logic [7:0] s;
    case (d)
      4'd0:    s = 8'h7E;
      4'd1:    s = 8'h30;
      4'd2:    s = 8'h6D;
      4'd3:    s = 8'h79;
      4'd4:    s = 8'h33;
      4'd5:    s = 8'h5B;
      4'd6:    s = 8'h5F;
      4'd7:    s = 8'h70;
      4'd8:    s = 8'h7F;
      4'd9:    s = 8'h7B;
      // Anything past 9 is blank
      default: s = 8'h00;
    endcase
    return s;
  endfunction

  // Decimal split, score tops out at 99
  assign tens_digit  = 4'(score / 7'd10);
  assign units_digit = 4'(score % 7'd10);

  assign tens  = seg7(tens_digit);
  assign units = seg7(units_digit);

endmodule

// ==== verilog/top.sv ====
`timescale 1ns/1ps

module top
  import tetris_pkg::*;
(
  input  logic        hz100,
  input  logic        arst_n,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic [7:0]  ss7,
  output logic [7:0]  ss6,
  output logic [7:0]  ss5,
  output logic [7:0]  ss4,
  output logic [7:0]  ss3,
  output logic [7:0]  ss2,
  output logic [7:0]  ss1,
  output logic [7:0]  ss0,
  output logic        red,
  output logic        green,
  output logic        blue
);

  buttons_t   buttons;
  vga_pos_t   pos;
  board_t     board;
  piece_t     piece;
  color_t     pix;
  logic       tick;
  logic       gameover;
  logic [6:0] score;

  // Unused pins held low
  assign right = '0;
  assign {ss7, ss6, ss5, ss4, ss3, ss2} = '0;
  assign left[2:0] = '0;
  assign green = 1'b0;
  assign blue  = 1'b0;

  // Pixel colour to the VGA connector, game over on the red LED
  assign left[5:3] = pix;
  assign red       = gameover;

  vga_timing u_vga_timing (.hz100(hz100), .arst_n(arst_n), .pos(pos));

  input_sync u_input_sync (.hz100(hz100), .arst_n(arst_n), .pb(pb), .buttons(buttons));

  drop_timer u_drop_timer (
    .hz100(hz100), .arst_n(arst_n), .score(score), .speed(buttons.speed), .tick(tick)
  );

  tetris_fsm u_tetris_fsm (
    .hz100(hz100), .arst_n(arst_n), .buttons(buttons), .tick(tick),
    .board(board), .piece(piece), .gameover(gameover), .score(score)
  );

  board_render u_board_render (
    .hz100(hz100), .arst_n(arst_n), .pos(pos), .board(board), .piece(piece),
    .gameover(gameover), .vga_rgb(pix), .hsync(left[7]), .vsync(left[6])
  );

  score_display u_score_display (.score(score), .tens(ss1), .units(ss0));

endmodule

// ==== tests/tb_assertions.sv ====
`timescale 1ns/1ps

module tb_assertions (
  input logic       hz100,
  input logic       arst_n,
  input logic       hsync,
  input logic       gameover,
  input logic       new_game,
  input logic [6:0] score
);

  // Length of the current hsync low pulse
  logic [6:0] low_cnt;

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      low_cnt <= '0;
    end else if (!hsync) begin
      low_cnt <= low_cnt + 7'd1;
    end else begin
      low_cnt <= '0;
    end
  end

  // Sync pulse is exactly 96 pixel clocks
  hsync_width: assert property (@(posedge hz100) disable iff (!arst_n)
    $rose(hsync) |-> (low_cnt == 7'd96))
    else $error("hsync low width wrong");

  // Only a new game leaves the over state
  gameover_hold: assert property (@(posedge hz100) disable iff (!arst_n)
    (gameover && !new_game) |=> gameover)
    else $error("gameover dropped without new game");

  score_limit: assert property (@(posedge hz100) disable iff (!arst_n)
    score <= 7'd99)
    else $error("score above 99");

endmodule

bind vga_timing tb_assertions u_vga_chk (
  .hz100(hz100), .arst_n(arst_n), .hsync(pos.hsync),
  .gameover(1'b0), .new_game(1'b0), .score(7'd0)
);

bind tetris_fsm tb_assertions u_fsm_chk (
  .hz100(hz100), .arst_n(arst_n), .hsync(1'b1),
  .gameover(gameover), .new_game(buttons.new_game), .score(score)
);

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module tb_top
  import tetris_pkg::*;
();

  localparam int frame_cycles = `H_TOTAL * `V_TOTAL;
  localparam int cycle_limit  = 30 * 420000;
  // Lines from the start of vsync to line 0 of the next frame
  localparam int vs_to_top    = `V_TOTAL - `V_VISIBLE - `V_FRONT;
  localparam logic [7:0] seg_0 = 8'h7E;
  localparam logic [7:0] seg_1 = 8'h30;

  logic        hz100;
  logic        arst_n;
  logic [20:0] pb;
  logic [7:0]  left;
  logic [7:0]  right;
  logic [7:0]  ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0;
  logic        red;
  logic        green;
  logic        blue;

  int   cyc;
  int   vs_fall;
  logic vs_prev;

  top uut (
    .hz100(hz100), .arst_n(arst_n), .pb(pb), .left(left), .right(right),
    .ss7(ss7), .ss6(ss6), .ss5(ss5), .ss4(ss4), .ss3(ss3), .ss2(ss2),
    .ss1(ss1), .ss0(ss0), .red(red), .green(green), .blue(blue)
  );

  initial begin
    hz100 = 1'b0;
    forever #4 hz100 = ~hz100;
  end

  // Cycle count and run limit
  always @(posedge hz100) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("timeout, the run went past its cycle limit");
      $display("Test failed");
      $fatal(1);
    end
  end

  // Cycle of the last vsync falling edge on the pin
  always @(negedge hz100) begin
    vs_prev <= left[6];
    if (vs_prev && !left[6]) begin
      vs_fall <= cyc;
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_color(input string name, input color_t got, input color_t want);
    if (got !== want) begin
      stop_run($sformatf("error: %s got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_segments(input string name, input logic [7:0] got,
                                input logic [7:0] want);
    if (got !== want) begin
      stop_run($sformatf("error: %s got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      stop_run($sformatf("error: %s got %h expected %h", name, got, want));
    end
  endtask

  // Next cycle after the given one at which cell (c, r) leaves the renderer
  function automatic int next_scan(input int c, input int r, input int after);
    int x;
    int y;
    int t;
    x = `BOARD_X0 + c * `CELL_PX + 8;
    y = `BOARD_Y0 + r * `CELL_PX + 8;
    t = vs_fall + (vs_to_top + y) * `H_TOTAL + x;
    while (t <= after) begin
      t += frame_cycles;
    end
    return t;
  endfunction

  task automatic wait_until(input int t);
    while (cyc < t) begin
      @(negedge hz100);
    end
  endtask

  task automatic check_cell(input string name, input int target, input color_t want);
    if (cyc >= target) begin
      stop_run($sformatf("scan of %s was over before the game reached it", name));
    end
    do begin
      @(negedge hz100);
    end while (cyc < target);
    check_color(name, color_t'(left[5:3]), want);
  endtask

  // Button held for a few random cycles and then released
  task automatic press(input int idx);
    int hold;
    hold = 1 + int'($urandom % 3);
    @(posedge hz100);
    #1 pb[idx] = 1'b1;
    repeat (hold) @(posedge hz100);
    #1 pb[idx] = 1'b0;
    repeat (5) @(posedge hz100);
  endtask

  task automatic press_n(input int idx, input int n);
    for (int i = 0; i < n; i++) begin
      press(idx);
    end
  endtask

  task automatic wait_fall();
    do begin
      @(negedge hz100);
    end while (uut.u_tetris_fsm.state != fall);
  endtask

  task automatic wait_next_piece();
    while (uut.u_tetris_fsm.state == fall) begin
      @(negedge hz100);
    end
    wait_fall();
  endtask

  task automatic test_reset();
    check_flag("hsync", left[7], 1'b1);
    check_flag("vsync", left[6], 1'b1);
    check_flag("red", red, 1'b0);
    check_segments("ss1", ss1, seg_0);
    check_segments("ss0", ss0, seg_0);
    // Pins with no function stay low
    check_segments("left[2:0]", {5'b0, left[2:0]}, 8'h00);
    check_segments("right", right, 8'h00);
    check_segments("ss7", ss7, 8'h00);
    check_segments("ss6", ss6, 8'h00);
    check_segments("ss5", ss5, 8'h00);
    check_segments("ss4", ss4, 8'h00);
    check_segments("ss3", ss3, 8'h00);
    check_segments("ss2", ss2, 8'h00);
    check_flag("green", green, 1'b0);
    check_flag("blue", blue, 1'b0);
    press(19);
    while (vs_fall < 0) begin
      @(negedge hz100);
    end
    check_cell("frame cell", next_scan(-1, 0, cyc + 10), color_blue);
    check_cell("empty cell", next_scan(0, 10, cyc + 10), color_black);
  endtask

  task automatic test_lock();
    int t;
    t = next_scan(3, 19, cyc + 4100);
    wait_until(t - 4000);
    press(19);
    check_cell("square col 3", t, color_white);
    check_cell("square col 4", t + 16, color_white);
    check_cell("right of square", t + 32, color_black);
  endtask

  task automatic test_clear();
    int t;
    t = next_scan(3, 19, cyc + 12100);
    wait_until(t - 12000);
    press(19);
    wait_fall();
    press(0);
    wait_next_piece();
    press_n(3, 3);
    wait_next_piece();
    press_n(3, 3);
    wait_next_piece();
    press_n(0, 3);
    wait_next_piece();
    check_segments("ss1", ss1, seg_0);
    check_segments("ss0", ss0, seg_1);
    check_cell("cleared col 3", t, color_black);
    check_cell("shifted col 4", t + 16, color_white);
    check_cell("shifted col 5", t + 32, color_white);
  endtask

  task automatic test_rotate_blocked();
    int t;
    t = next_scan(6, 19, cyc + 6100);
    wait_until(t - 6000);
    press(19);
    wait_fall();
    wait_next_piece();
    press_n(0, 4);
    press(8);
    wait_next_piece();
    check_cell("bar col 6", t, color_white);
    check_cell("bar col 7", t + 16, color_white);
    check_cell("bar col 9", t + 48, color_white);
  endtask

  task automatic test_speed();
    int start;
    @(posedge hz100);
    #1 pb[12] = 1'b1;
    press(19);
    wait_fall();
    start = cyc;
    while (uut.u_tetris_fsm.state == fall) begin
      @(negedge hz100);
    end
    check_flag("fast drop in bound", (cyc - start) <= 20 * `DROP_FAST + 40, 1'b1);
    @(posedge hz100);
    #1 pb[12] = 1'b0;
  endtask

  task automatic test_game_over();
    int t;
    // Unmoved pieces stack on the board left by the row clear
    while (!red) begin
      @(negedge hz100);
    end
    check_segments("ss1", ss1, seg_0);
    check_segments("ss0", ss0, seg_1);
    check_cell("locked at over", next_scan(4, 19, cyc + 10), color_red);
    t = next_scan(4, 19, cyc + 1000);
    wait_until(t - 500);
    press(19);
    check_flag("red", red, 1'b0);
    check_segments("ss1", ss1, seg_0);
    check_segments("ss0", ss0, seg_0);
    check_cell("cleared board", t, color_black);
  endtask

  initial begin
    void'($urandom(98562));
    arst_n   = 1'b0;
    pb       = '0;
    cyc      = 0;
    vs_fall  = -1;
    vs_prev  = 1'b1;
    repeat (16) @(posedge hz100);
    #1 arst_n = 1'b1;
    test_reset();
    test_lock();
    test_clear();
    test_game_over();
    test_rotate_blocked();
    test_speed();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== tetris.f ====
+incdir+verilog
verilog/tetris_pkg.sv
verilog/vga_timing.sv
verilog/input_sync.sv
verilog/drop_timer.sv
verilog/tetris_fsm.sv
verilog/board_render.sv
verilog/score_display.sv
verilog/top.sv
tests/tb_assertions.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f tetris.f -o tb_top
./obj_dir/tb_top
